/* vlog.f */
src/bp_pkg.sv
src/gen_fifo.sv
src/gen_ring_stack.sv
src/pre_decode.sv
src/branch_predict.sv
src/branch_unit_top.sv
verif/tb_branch_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the branch unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_branch_unit \
	--Mdir obj_dir -o tb_branch_unit
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_branch_unit)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi

echo "simulation did not report a pass"
exit 1

/* verif/tb_branch_unit.sv */
// Testbench for the branch unit top level.
// Directed tests of static prediction, misprediction, jumps, the return
// stack, unpredicted jalr, back-pressure and flush.
`timescale 1ns/1ps

module tb_branch_unit;

	// cycles that any wait may last.
	localparam int TIMEOUT = 64;

	logic CLK;
	logic reset;
	logic flush;
	bp_pkg::rv_instr_u instr;
	logic instr_valid;
	logic [bp_pkg::XLEN-1:0] pc_load;
	logic id_ready;
	logic bru_res_valid;
	logic bru_taken;
	logic jalr_valid;
	logic [bp_pkg::XLEN-1:0] jalr_pc;
	logic branch_pc_valid;
	logic [bp_pkg::XLEN-1:0] branch_pc;
	logic mis_predict;
	logic jalr_stall;
	logic bht_stall;

	int errors;
	int checks;
	integer seed;

	branch_unit_top dut_i (
		.CLK(CLK),
		.reset(reset),
		.flush(flush),
		.instr(instr),
		.instr_valid(instr_valid),
		.pc_load(pc_load),
		.id_ready(id_ready),
		.bru_res_valid(bru_res_valid),
		.bru_taken(bru_taken),
		.jalr_valid(jalr_valid),
		.jalr_pc(jalr_pc),
		.branch_pc_valid(branch_pc_valid),
		.branch_pc(branch_pc),
		.mis_predict(mis_predict),
		.jalr_stall(jalr_stall),
		.bht_stall(bht_stall)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// sign-extend a 32-bit offset to an address.
	function automatic logic [bp_pkg::XLEN-1:0] sx(input int v);
		return {{32{v[31]}}, v};
	endfunction

	// beq x5, x6 with the given byte offset.
	function automatic bp_pkg::rv_instr_u enc_branch(input logic [bp_pkg::XLEN-1:0] off);
		bp_pkg::rv_instr_u w;
		w.b.imm12 = off[12];
		w.b.imm10_5 = off[10:5];
		w.b.rs2 = 5'd6;
		w.b.rs1 = 5'd5;
		w.b.funct3 = 3'b000;
		w.b.imm4_1 = off[4:1];
		w.b.imm11 = off[11];
		w.b.opcode = bp_pkg::OPC_BRANCH;
		return w;
	endfunction

	function automatic bp_pkg::rv_instr_u enc_jal(input logic [bp_pkg::XLEN-1:0] off,
		input logic [4:0] rd);
		bp_pkg::rv_instr_u w;
		w.j.imm20 = off[20];
		w.j.imm10_1 = off[10:1];
		w.j.imm11 = off[11];
		w.j.imm19_12 = off[19:12];
		w.j.rd = rd;
		w.j.opcode = bp_pkg::OPC_JAL;
		return w;
	endfunction

	// jalr rd, 0(rs1).
	function automatic bp_pkg::rv_instr_u enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
		bp_pkg::rv_instr_u w;
		w.i.imm = 12'h000;
		w.i.rs1 = rs1;
		w.i.funct3 = 3'b000;
		w.i.rd = rd;
		w.i.opcode = bp_pkg::OPC_JALR;
		return w;
	endfunction

	// c.j with offset bits in the order 11|4|9:8|10|6|7|3:1|5.
	function automatic bp_pkg::rv_instr_u enc_cj(input logic [bp_pkg::XLEN-1:0] off);
		logic [15:0] c;
		bp_pkg::rv_instr_u w;
		c = {3'b101, off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1], off[5], 2'b01};
		w = {16'h0000, c};
		return w;
	endfunction

	// c.beqz x8 with offset bits 8|4:3 and 7:6|2:1|5.
	function automatic bp_pkg::rv_instr_u enc_cbeqz(input logic [bp_pkg::XLEN-1:0] off);
		logic [15:0] c;
		bp_pkg::rv_instr_u w;
		c = {3'b110, off[8], off[4:3], 3'b000, off[7:6], off[2:1], off[5], 2'b01};
		w = {16'h0000, c};
		return w;
	endfunction

	task automatic check_pc(input string name, input logic [bp_pkg::XLEN-1:0] exp,
		input logic [bp_pkg::XLEN-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERR %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("ERR %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic drive_idle();
		flush = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		pc_load = '0;
		id_ready = 1'b1;
		bru_res_valid = 1'b0;
		bru_taken = 1'b0;
		jalr_valid = 1'b0;
		jalr_pc = '0;
	endtask

	// wait for the next falling edge and return the inputs to idle.
	task automatic step();
		@(posedge CLK);
		@(negedge CLK);
		drive_idle();
		#1;
	endtask

	task automatic issue(input bp_pkg::rv_instr_u w, input logic [bp_pkg::XLEN-1:0] pc);
		instr = w;
		instr_valid = 1'b1;
		pc_load = pc;
		#1;
	endtask

	task automatic resolve(input logic taken);
		bru_res_valid = 1'b1;
		bru_taken = taken;
		#1;
	endtask

	task automatic flush_all();
		flush = 1'b1;
		#1;
		step();
	endtask

	task automatic check_idle(input string name);
		check_bit({name, " branch_pc_valid"}, 1'b0, branch_pc_valid);
		check_pc({name, " branch_pc"}, '0, branch_pc);
		check_bit({name, " mis_predict"}, 1'b0, mis_predict);
		check_bit({name, " jalr_stall"}, 1'b0, jalr_stall);
		check_bit({name, " bht_stall"}, 1'b0, bht_stall);
	endtask

	// hold a stalled jalr while execute answers after the given latency.
	task automatic wait_jalr_target(input string name, input int latency,
		input logic [bp_pkg::XLEN-1:0] target);
		int cycles;
		cycles = 0;
		while (jalr_stall && cycles < TIMEOUT) begin
			check_bit({name, " redirect while stalled"}, 1'b0, branch_pc_valid);
			@(posedge CLK);
			@(negedge CLK);
			cycles++;
			if (cycles == latency) begin
				jalr_valid = 1'b1;
				jalr_pc = target;
			end
			#1;
		end
		if (jalr_stall) begin
			errors++;
			$display("%s: jalr_stall never dropped within %0d cycles", name, TIMEOUT);
		end else begin
			check_count({name, " stall cycles"}, latency, cycles);
			check_bit({name, " branch_pc_valid"}, 1'b1, branch_pc_valid);
			check_pc({name, " branch_pc"}, target, branch_pc);
		end
		step();
	endtask

	task automatic test_static();
		issue(enc_branch(sx(-16)), 64'h1000);
		check_bit("static backward valid", 1'b1, branch_pc_valid);
		check_pc("static backward target", 64'h1000 + sx(-16), branch_pc);
		check_bit("static backward bht_stall", 1'b0, bht_stall);
		step();
		issue(enc_branch(sx(32)), 64'h2000);
		check_bit("static forward valid", 1'b0, branch_pc_valid);
		step();
		resolve(1'b1);
		check_bit("static backward resolve", 1'b0, mis_predict);
		step();
		resolve(1'b0);
		check_bit("static forward resolve", 1'b0, mis_predict);
		step();
	endtask

	// three branches outstanding and all resolved against the prediction.
	task automatic test_mispredict();
		issue(enc_branch(sx(64)), 64'h3000);
		step();
		issue(enc_branch(sx(-40)), 64'h3100);
		step();
		issue(enc_cbeqz(sx(-20)), 64'h3200);
		check_bit("c.beqz valid", 1'b1, branch_pc_valid);
		check_pc("c.beqz target", 64'h3200 + sx(-20), branch_pc);
		step();
		resolve(1'b1);
		check_bit("forward taken mis_predict", 1'b1, mis_predict);
		check_pc("forward taken target", 64'h3000 + sx(64), branch_pc);
		step();
		resolve(1'b0);
		check_bit("backward not taken mis_predict", 1'b1, mis_predict);
		check_pc("backward not taken pc", 64'h3104, branch_pc);
		step();
		resolve(1'b0);
		check_bit("c.beqz not taken mis_predict", 1'b1, mis_predict);
		check_pc("c.beqz not taken pc", 64'h3202, branch_pc);
		step();
	endtask

	task automatic test_jumps();
		int i;
		int r;
		logic [bp_pkg::XLEN-1:0] off;
		for (i = 0; i < 4; i++) begin
			r = $random(seed);
			off = {{43{r[20]}}, r[20:1], 1'b0};
			issue(enc_jal(off, 5'd0), 64'h8000_0000);
			check_bit("jal valid", 1'b1, branch_pc_valid);
			check_pc("jal target", 64'h8000_0000 + off, branch_pc);
			check_bit("jal jalr_stall", 1'b0, jalr_stall);
			step();
			r = $random(seed);
			off = {{52{r[11]}}, r[11:1], 1'b0};
			issue(enc_cj(off), 64'h8000_1000);
			check_bit("c.j valid", 1'b1, branch_pc_valid);
			check_pc("c.j target", 64'h8000_1000 + off, branch_pc);
			step();
		end
	endtask

	task automatic test_calls();
		int i;
		logic [bp_pkg::XLEN-1:0] addr;
		flush_all();
		issue(enc_jal(sx(256), 5'd1), 64'h4000);
		check_pc("call target", 64'h4100, branch_pc);
		step();
		issue(enc_jalr(5'd0, 5'd1), 64'h4100);
		check_bit("return jalr_stall", 1'b0, jalr_stall);
		check_bit("return valid", 1'b1, branch_pc_valid);
		check_pc("return target", 64'h4004, branch_pc);
		step();
		jalr_valid = 1'b1;
		jalr_pc = 64'h4004;
		#1;
		check_bit("predicted return result", 1'b0, branch_pc_valid);
		step();
		// seventeen calls push the first one off the stack.
		addr = 64'h6000;
		for (i = 0; i < 17; i++) begin
			issue(enc_jal(sx(64), 5'd5), addr);
			step();
			addr = addr + 64'h40;
		end
		for (i = 0; i < 16; i++) begin
			addr = addr - 64'h40;
			issue(enc_jalr(5'd0, 5'd5), 64'h7000);
			check_bit("deep return jalr_stall", 1'b0, jalr_stall);
			check_pc("deep return target", addr + 64'h4, branch_pc);
			step();
		end
		for (i = 0; i < 16; i++) begin
			jalr_valid = 1'b1;
			#1;
			check_bit("deep return result", 1'b0, branch_pc_valid);
			step();
		end
		issue(enc_jalr(5'd0, 5'd1), 64'h7100);
		check_bit("empty return jalr_stall", 1'b1, jalr_stall);
		wait_jalr_target("empty return", 2, 64'h7200);
	endtask

	task automatic test_jalr();
		int latency;
		latency = 2 + ($random(seed) & 7);
		issue(enc_jalr(5'd0, 5'd6), 64'h5000);
		check_bit("jalr jalr_stall", 1'b1, jalr_stall);
		wait_jalr_target("jalr", latency, 64'h0000_1234_5678_9abc);
	endtask

	task automatic test_backpressure();
		int i;
		logic [bp_pkg::XLEN-1:0] addr;
		flush_all();
		addr = 64'h9000;
		for (i = 0; i < 16; i++) begin
			issue(enc_branch(sx(8)), addr);
			check_bit("fill bht_stall", 1'b0, bht_stall);
			step();
			addr = addr + 64'h4;
		end
		issue(enc_branch(sx(-8)), addr);
		check_bit("full bht_stall", 1'b1, bht_stall);
		check_bit("full valid", 1'b0, branch_pc_valid);
		step();
		for (i = 0; i < 16; i++) begin
			resolve(1'b0);
			check_bit("drain mis_predict", 1'b0, mis_predict);
			step();
		end
		// the held branch was predicted taken and must not be queued.
		resolve(1'b0);
		check_bit("held branch mis_predict", 1'b0, mis_predict);
		step();
		id_ready = 1'b0;
		issue(enc_branch(sx(-8)), 64'h9800);
		step();
		resolve(1'b0);
		check_bit("not ready branch mis_predict", 1'b0, mis_predict);
		step();
		id_ready = 1'b0;
		issue(enc_jal(sx(16), 5'd1), 64'h9900);
		step();
		issue(enc_jalr(5'd0, 5'd1), 64'h9a00);
		check_bit("not ready call jalr_stall", 1'b1, jalr_stall);
		wait_jalr_target("not ready call", 1, 64'h9b00);
	endtask

	task automatic test_flush();
		issue(enc_branch(sx(-8)), 64'ha000);
		step();
		issue(enc_jal(sx(16), 5'd1), 64'ha100);
		step();
		flush_all();
		resolve(1'b0);
		check_bit("flushed branch mis_predict", 1'b0, mis_predict);
		check_bit("flushed branch valid", 1'b0, branch_pc_valid);
		step();
		issue(enc_jalr(5'd0, 5'd1), 64'ha200);
		check_bit("flushed return jalr_stall", 1'b1, jalr_stall);
		check_bit("flushed return valid", 1'b0, branch_pc_valid);
		step();
		check_idle("after flush");
	endtask

	initial begin
		seed = 61783;
		errors = 0;
		checks = 0;
		drive_idle();
		reset = 1'b1;
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		#1;
		check_idle("after reset");
		test_static();
		test_mispredict();
		test_jumps();
		test_calls();
		test_jalr();
		test_backpressure();
		test_flush();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* src/branch_unit_top.sv */
// Branch unit top level.
// Joins the pre-decoder and the static predictor of the decode stage.
`timescale 1ns/1ps

module branch_unit_top (
	input logic CLK,
	input logic reset,
	input logic flush,
	input bp_pkg::rv_instr_u instr,
	input logic instr_valid,
	input logic [bp_pkg::XLEN-1:0] pc_load,
	input logic id_ready,
	input logic bru_res_valid,
	input logic bru_taken,
	input logic jalr_valid,
	input logic [bp_pkg::XLEN-1:0] jalr_pc,
	output logic branch_pc_valid,
	output logic [bp_pkg::XLEN-1:0] branch_pc,
	output logic mis_predict,
	output logic jalr_stall,
	output logic bht_stall
);

	// pre-decode results.
	logic is_jal;
	logic is_jalr;
	logic is_branch;
	logic is_call;
	logic is_return;
	logic is_rvc;
	logic [bp_pkg::XLEN-1:0] imm;

	pre_decode pre_decode_i (
		.instr(instr),
		.instr_valid(instr_valid),
		.is_jal(is_jal),
		.is_jalr(is_jalr),
		.is_branch(is_branch),
		.is_call(is_call),
		.is_return(is_return),
		.is_rvc(is_rvc),
		.imm(imm)
	);

	branch_predict branch_predict_i (
		.CLK(CLK),
		.reset(reset),
		.flush(flush),
		.is_jal(is_jal),
		.is_jalr(is_jalr),
		.is_branch(is_branch),
		.is_call(is_call),
		.is_return(is_return),
		.imm(imm),
		.is_rvc(is_rvc),
		.pc_load(pc_load),
		.id_ready(id_ready),
		.bru_res_valid(bru_res_valid),
		.bru_taken(bru_taken),
		.jalr_valid(jalr_valid),
		.jalr_pc(jalr_pc),
		.branch_pc_valid(branch_pc_valid),
		.branch_pc(branch_pc),
		.mis_predict(mis_predict),
		.jalr_stall(jalr_stall),
		.bht_stall(bht_stall)
	);

endmodule

/* src/branch_predict.sv */
// Static branch predictor.
// Predicts backward branches taken, uses a return stack for returns and
// queues unresolved branches so that a later result can redirect fetch.
`timescale 1ns/1ps

module branch_predict (
	input logic CLK,
	input logic reset,
	input logic flush,
	input logic is_jal,
	input logic is_jalr,
	input logic is_branch,
	input logic is_call,
	input logic is_return,
	input logic [bp_pkg::XLEN-1:0] imm,
	input logic is_rvc,
	input logic [bp_pkg::XLEN-1:0] pc_load,
	input logic id_ready,
	input logic bru_res_valid,
	input logic bru_taken,
	input logic jalr_valid,
	input logic [bp_pkg::XLEN-1:0] jalr_pc,
	output logic branch_pc_valid,
	output logic [bp_pkg::XLEN-1:0] branch_pc,
	output logic mis_predict,
	output logic jalr_stall,
	output logic bht_stall
);

	logic [bp_pkg::XLEN-1:0] next_pc;
	logic [bp_pkg::XLEN-1:0] take_pc;
	logic br_pred;
	logic br_taken;
	logic is_taken;
	logic [bp_pkg::XLEN:0] bht_data_push;
	logic [bp_pkg::XLEN:0] bht_data_pop;
	logic bht_push;
	logic bht_pop;
	logic bht_full;
	logic bht_empty;
	logic [bp_pkg::XLEN-1:0] ras_top;
	logic ras_push;
	logic ras_pop;
	logic ras_empty;
	logic ras_cnt_empty;
	logic jalr_last;
	logic jalr_front;

	assign next_pc = pc_load + (is_rvc ? 64'd2 : 64'd4);

	// a backward branch is taken and a forward one is not.
	assign br_pred = imm[bp_pkg::XLEN-1];
	// no redirect for a branch held back by a full queue.
	assign br_taken = is_branch && br_pred && !bht_full;

	// predicted returns pop and calls push the link address.
	assign ras_pop = is_return && is_jalr && !ras_empty && id_ready;
	assign ras_push = is_call && id_ready && !jalr_stall;

	assign is_taken = br_taken || is_jal || ras_pop;
	assign take_pc = ras_pop ? ras_top : (pc_load + imm);

	// keep the prediction and the path not followed.
	assign bht_data_push = {br_pred, (br_pred ? next_pc : take_pc)};
	assign bht_push = is_branch && !bht_full && id_ready;
	// stray results after a flush find the queue empty.
	assign bht_pop = bru_res_valid && !bht_empty;
	assign mis_predict = bht_pop && (bru_taken != bht_data_pop[bp_pkg::XLEN]);

	// jalr results for predicted returns are swallowed.
	assign jalr_front = jalr_valid && !ras_cnt_empty;
	assign jalr_last = jalr_valid && ras_cnt_empty;

	assign jalr_stall = is_jalr && !jalr_last && (ras_empty || !is_return);
	assign bht_stall = is_branch && bht_full;

	// redirect priority is misprediction, then prediction, then execute target.
	assign branch_pc_valid = mis_predict || is_taken || jalr_last;
	always_comb begin
		if (mis_predict) begin
			branch_pc = bht_data_pop[bp_pkg::XLEN-1:0];
		end else if (is_taken) begin
			branch_pc = take_pc;
		end else if (jalr_last) begin
			branch_pc = jalr_pc;
		end else begin
			branch_pc = '0;
		end
	end

	gen_fifo #(
		.DW(bp_pkg::XLEN + 1),
		.AW(bp_pkg::BHT_AW)
	) bht_q (
		.CLK(CLK),
		.reset(reset),
		.flush(flush),
		.fifo_push(bht_push),
		.fifo_pop(bht_pop),
		.data_push(bht_data_push),
		.data_pop(bht_data_pop),
		.fifo_empty(bht_empty),
		.fifo_full(bht_full)
	);

	gen_ring_stack #(
		.DW(bp_pkg::XLEN),
		.AW(bp_pkg::RAS_AW)
	) ras (
		.CLK(CLK),
		.reset(reset),
		.flush(flush),
		.stack_push(ras_push),
		.stack_pop(ras_pop),
		.data_push(next_pc),
		.data_pop(ras_top),
		.stack_empty(ras_empty)
	);

	// one token per predicted return still waiting for execute.
	gen_fifo #(
		.DW(1),
		.AW(bp_pkg::RAS_AW)
	) ras_cnt_q (
		.CLK(CLK),
		.reset(reset),
		.flush(flush),
		.fifo_push(ras_pop),
		.fifo_pop(jalr_front),
		.data_push(1'b1),
		.data_pop(),
		.fifo_empty(ras_cnt_empty),
		.fifo_full()
	);

	// an execute jalr target only comes back while decode waits on it.
	assert property (@(posedge CLK) disable iff (reset) !(is_taken && jalr_last));

endmodule

/* src/pre_decode.sv */
// Branch pre-decoder.
// Classifies a 32-bit or 16-bit instruction as branch, jal, jalr, call or
// return and builds its sign-extended immediate.
`timescale 1ns/1ps

module pre_decode (
	input bp_pkg::rv_instr_u instr,
	input logic instr_valid,
	output logic is_jal,
	output logic is_jalr,
	output logic is_branch,
	output logic is_call,
	output logic is_return,
	output logic is_rvc,
	output logic [bp_pkg::XLEN-1:0] imm
);

	logic [15:0] c_instr;
	logic rvc;
	logic [4:0] c_rs1;
	logic [4:0] c_rs2;
	logic c_j;
	logic c_br;
	logic c_jr;
	logic c_jalr;
	logic f_jal;
	logic f_jalr;
	logic f_br;
	logic [bp_pkg::XLEN-1:0] imm_j;
	logic [bp_pkg::XLEN-1:0] imm_b;
	logic [bp_pkg::XLEN-1:0] imm_cj;
	logic [bp_pkg::XLEN-1:0] imm_cb;

	// x1 and x5 are the link registers.
	function automatic logic is_link(input logic [4:0] r);
		return (r == 5'd1) || (r == 5'd5);
	endfunction

	// compressed encodings live in the low half.
	assign c_instr = instr[15:0];
	assign rvc = (c_instr[1:0] != 2'b11);
	assign c_rs1 = c_instr[11:7];
	assign c_rs2 = c_instr[6:2];

	// c.j, c.beqz and c.bnez sit in quadrant 1.
	assign c_j = (c_instr[1:0] == 2'b01) && (c_instr[15:13] == 3'b101);
	assign c_br = (c_instr[1:0] == 2'b01) && (c_instr[15:14] == 2'b11);
	// c.jr and c.jalr sit in quadrant 2 and differ in bit 12.
	assign c_jr = (c_instr[1:0] == 2'b10) && (c_instr[15:12] == 4'b1000)
		&& (c_rs2 == 5'd0) && (c_rs1 != 5'd0);
	assign c_jalr = (c_instr[1:0] == 2'b10) && (c_instr[15:12] == 4'b1001)
		&& (c_rs2 == 5'd0) && (c_rs1 != 5'd0);

	// full size words read the opcode through the matching view.
	assign f_jal = !rvc && (instr.j.opcode == bp_pkg::OPC_JAL);
	assign f_jalr = !rvc && (instr.i.opcode == bp_pkg::OPC_JALR) && (instr.i.funct3 == 3'b000);
	assign f_br = !rvc && (instr.b.opcode == bp_pkg::OPC_BRANCH);

	// sign-extended offsets.
	assign imm_j = {{(bp_pkg::XLEN-20){instr.j.imm20}}, instr.j.imm19_12,
		instr.j.imm11, instr.j.imm10_1, 1'b0};
	assign imm_b = {{(bp_pkg::XLEN-12){instr.b.imm12}}, instr.b.imm11,
		instr.b.imm10_5, instr.b.imm4_1, 1'b0};
	// cj offset[11|4|9:8|10|6|7|3:1|5].
	assign imm_cj = {{(bp_pkg::XLEN-11){c_instr[12]}}, c_instr[8], c_instr[10:9],
		c_instr[6], c_instr[7], c_instr[2], c_instr[11], c_instr[5:3], 1'b0};
	// cb offset[8|4:3] and [7:6|2:1|5].
	assign imm_cb = {{(bp_pkg::XLEN-8){c_instr[12]}}, c_instr[6:5], c_instr[2],
		c_instr[11:10], c_instr[4:3], 1'b0};

	always_comb begin
		is_jal = 1'b0;
		is_jalr = 1'b0;
		is_branch = 1'b0;
		is_call = 1'b0;
		is_return = 1'b0;
		is_rvc = 1'b0;
		imm = '0;
		if (instr_valid) begin
			is_jal = f_jal || c_j;
			is_jalr = f_jalr || c_jr || c_jalr;
			is_branch = f_br || c_br;
			// c.jalr always links through x1.
			is_call = (f_jal && is_link(instr.j.rd))
				|| (f_jalr && is_link(instr.i.rd)) || c_jalr;
			is_return = (f_jalr && (instr.i.rd == 5'd0) && is_link(instr.i.rs1))
				|| (c_jr && is_link(c_rs1));
			is_rvc = rvc;
			// jalr target comes from the stack or execute.
			if (c_j) begin
				imm = imm_cj;
			end else if (c_br) begin
				imm = imm_cb;
			end else if (f_br) begin
				imm = imm_b;
			end else if (f_jal) begin
				imm = imm_j;
			end
		end
	end

endmodule

/* src/gen_ring_stack.sv */
// Generic ring stack for return addresses.
// A push beyond the depth overwrites the oldest entry.
// A push and a pop in one cycle replace the top entry.
`timescale 1ns/1ps

module gen_ring_stack #(
	parameter int DW = 64,
	parameter int AW = 4
) (
	input logic CLK,
	input logic reset,
	input logic flush,
	input logic stack_push,
	input logic stack_pop,
	input logic [DW-1:0] data_push,
	output logic [DW-1:0] data_pop,
	output logic stack_empty
);

	logic [DW-1:0] mem [0:(1<<AW)-1];
	// index of the top entry.
	logic [AW-1:0] top;
	logic [AW-1:0] top_inc;
	// number of valid entries, saturates at the depth.
	logic [AW:0] count;

	assign top_inc = top + 1'b1;

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			top <= '0;
			count <= '0;
		end else begin
			case ({stack_push, stack_pop})
				2'b10: begin
					top <= top_inc;
					// oldest entry silently lost once full.
					if (count != {1'b1, {AW{1'b0}}}) begin
						count <= count + 1'b1;
					end
				end
				2'b01: begin
					top <= top - 1'b1;
					count <= count - 1'b1;
				end
				// push with pop keeps top and count.
				default: ;
			endcase
		end
	end

	// write port that replaces the top when popping in the same cycle.
	always_ff @(posedge CLK) begin
		if (stack_push && stack_pop) begin
			mem[top] <= data_push;
		end else if (stack_push) begin
			mem[top_inc] <= data_push;
		end
	end

	assign data_pop = mem[top];
	assign stack_empty = (count == '0);

	assert property (@(posedge CLK) disable iff (reset) !(stack_pop && stack_empty));

endmodule

/* src/gen_fifo.sv */
// Generic synchronous FIFO.
// Circular buffer of 2**AW entries with flush, full and empty flags.
// The head entry is visible on data_pop without delay.
`timescale 1ns/1ps

module gen_fifo #(
	parameter int DW = 8,
	parameter int AW = 4
) (
	input logic CLK,
	input logic reset,
	input logic flush,
	input logic fifo_push,
	input logic fifo_pop,
	input logic [DW-1:0] data_push,
	output logic [DW-1:0] data_pop,
	output logic fifo_empty,
	output logic fifo_full
);

	// entry storage.
	logic [DW-1:0] mem [0:(1<<AW)-1];
	// pointers carry one extra wrap bit.
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	// pointer update where flush drops every entry.
	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (fifo_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (fifo_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// write port.
	always_ff @(posedge CLK) begin
		if (fifo_push) begin
			mem[wr_ptr[AW-1:0]] <= data_push;
		end
	end

	assign data_pop = mem[rd_ptr[AW-1:0]];
	// full when the index matches and the wrap bits differ.
	assign fifo_empty = (wr_ptr == rd_ptr);
	assign fifo_full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// the user gates push and pop with the flags.
	assert property (@(posedge CLK) disable iff (reset) !(fifo_push && fifo_full));
	assert property (@(posedge CLK) disable iff (reset) !(fifo_pop && fifo_empty));

endmodule

/* src/bp_pkg.sv */
// Branch prediction package.
// Holds the width constants, the major opcodes and the packed union that
// decodes one 32-bit instruction word as a J, B or I format word.
package bp_pkg;

	// address and data width of the core.
	localparam int XLEN = 64;
	// branch queue depth is 2**BHT_AW.
	localparam int BHT_AW = 4;
	// return stack and return-count queue depth is 2**RAS_AW.
	localparam int RAS_AW = 4;

	// major opcodes of the control transfer instructions.
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// jal format with the immediate bits scattered over the upper word.
	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_j_t;

	// conditional branch format.
	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} rv_b_t;

	// register-immediate format used by jalr.
	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_i_t;

	// one instruction word seen in three views of the same 32 bits.
	typedef union packed {
		rv_j_t j;
		rv_b_t b;
		rv_i_t i;
	} rv_instr_u;

endpackage
